// ==== design/fu_defines.svh ====
`ifndef FU_DEFINES_SVH
`define FU_DEFINES_SVH

// Data path width in bits
`define XLEN 64

// Issue tag width, enough for 64 in-flight tags
`define TAG_W 6

// Multiply pipeline depth, any value of 2 or more
`define MULT_STAGES 4

// Instruction size in bytes
// Link step and displacement scale
`define INSN_BYTES 4

`endif

// ==== design/isa_pkg.sv ====
package isa_pkg;

  // Operations accepted at the issue port
  typedef enum logic [4:0] {
    OP_ADDQ   = 5'd0,
    OP_SUBQ   = 5'd1,
    OP_AND    = 5'd2,
    OP_BIC    = 5'd3,   // a & ~b
    OP_BIS    = 5'd4,   // a | b
    OP_ORNOT  = 5'd5,   // a | ~b
    OP_XOR    = 5'd6,
    OP_EQV    = 5'd7,   // a ^ ~b

    // Shifts by the low six bits of b
    OP_SRL    = 5'd8,
    OP_SLL    = 5'd9,
    OP_SRA    = 5'd10,

    // Compares, 0 or 1 in bit zero
    OP_CMPULT = 5'd11,
    OP_CMPEQ  = 5'd12,
    OP_CMPULE = 5'd13,
    OP_CMPLT  = 5'd14,
    OP_CMPLE  = 5'd15,

    OP_MULQ   = 5'd16,  // Low 64 bits of the product
    OP_BR     = 5'd17   // Condition comes on its own field
  } fu_op_e;

  // Branch conditions on operand a
  // Bit 2 negates the test picked by bits 1:0
  typedef enum logic [2:0] {
    BR_LBC = 3'b000,  // lsb clear
    BR_EQ  = 3'b001,
    BR_LT  = 3'b010,
    BR_LE  = 3'b011,
    BR_LBS = 3'b100,  // lsb set
    BR_NE  = 3'b101,
    BR_GE  = 3'b110,
    BR_GT  = 3'b111
  } br_cond_e;

endpackage

// ==== design/fu_pkg.sv ====
`include "fu_defines.svh"

package fu_pkg;

  // Data word and issue tag
  typedef logic [`XLEN-1:0]  word_t;
  typedef logic [`TAG_W-1:0] tag_t;

  // Which execution path an operation goes to
  typedef enum logic [1:0] {
    CLS_INT = 2'd0,   // ALU, one cycle
    CLS_BR  = 2'd1,   // Branch, one cycle
    CLS_MUL = 2'd2    // Multiply pipeline
  } exec_class_e;

  // Source that currently owns the completion port
  typedef enum logic [1:0] {
    SRC_NONE = 2'd0,
    SRC_INT  = 2'd1,
    SRC_MUL  = 2'd2
  } cpl_src_e;

endpackage

// ==== design/alu.sv ====
`include "fu_defines.svh"

module alu (
  input  isa_pkg::fu_op_e op,
  input  fu_pkg::word_t   a,
  input  fu_pkg::word_t   b,
  output fu_pkg::word_t   result
);

  logic [5:0]    shamt;
  fu_pkg::word_t sra_fill;
  logic          lt_s;
  logic          eq;

  // Signed a < b without signed types
  function automatic logic signed_lt(input fu_pkg::word_t x, input fu_pkg::word_t y);
    logic lt;
    if (x[`XLEN-1] == y[`XLEN-1]) begin
      lt = (x < y);       // Same sign, plain compare works
    end else begin
      lt = x[`XLEN-1];    // Negative one is smaller
    end
    return lt;
  endfunction

  assign shamt = b[5:0];
  assign lt_s  = signed_lt(a, b);
  assign eq    = (a == b);

  // Sign bits shifted into the top shamt positions
  assign sra_fill = a[`XLEN-1] ? ~({`XLEN{1'b1}} >> shamt) : '0;

  always_comb begin
    case (op)
      isa_pkg::OP_ADDQ:   result = a + b;
      isa_pkg::OP_SUBQ:   result = a - b;
      isa_pkg::OP_AND:    result = a & b;
      isa_pkg::OP_BIC:    result = a & ~b;
      isa_pkg::OP_BIS:    result = a | b;
      isa_pkg::OP_ORNOT:  result = a | ~b;
      isa_pkg::OP_XOR:    result = a ^ b;
      isa_pkg::OP_EQV:    result = a ^ ~b;

      isa_pkg::OP_SRL:    result = a >> shamt;
      isa_pkg::OP_SLL:    result = a << shamt;
      isa_pkg::OP_SRA:    result = (a >> shamt) | sra_fill;

      isa_pkg::OP_CMPULT: result = {{(`XLEN-1){1'b0}}, (a < b)};
      isa_pkg::OP_CMPEQ:  result = {{(`XLEN-1){1'b0}}, eq};
      isa_pkg::OP_CMPULE: result = {{(`XLEN-1){1'b0}}, (a <= b)};
      isa_pkg::OP_CMPLT:  result = {{(`XLEN-1){1'b0}}, lt_s};
      isa_pkg::OP_CMPLE:  result = {{(`XLEN-1){1'b0}}, (lt_s | eq)};

      // Multiply and branch are handled elsewhere
      default:            result = '0;
    endcase
  end

endmodule

// ==== design/br_unit.sv ====
`include "fu_defines.svh"

module br_unit (
  input  isa_pkg::br_cond_e cond,
  input  fu_pkg::word_t     a,
  input  fu_pkg::word_t     pc,
  input  fu_pkg::word_t     disp,
  output logic              taken,
  output fu_pkg::word_t     target,
  output fu_pkg::word_t     link
);

  logic          raw;       // Test result before negation
  logic          a_zero;
  logic          a_neg;
  fu_pkg::word_t disp_bytes;

  assign a_zero = (a == '0);
  assign a_neg  = a[`XLEN-1];

  // Base test from the low two condition bits
  always_comb begin
    case (cond[1:0])
      2'b00:   raw = ~a[0];           // LBC
      2'b01:   raw = a_zero;          // EQ
      2'b10:   raw = a_neg;           // LT
      default: raw = a_neg | a_zero;  // LE
    endcase
  end

  assign taken = raw ^ cond[2];

  // Next sequential pc doubles as the link value
  assign link = pc + `INSN_BYTES;

  // Displacement counts instructions
  assign disp_bytes = disp * `INSN_BYTES;
  assign target     = link + disp_bytes;

endmodule

// ==== design/mult_pipe.sv ====
`include "fu_defines.svh"

module mult_pipe (
  input  logic          clock,
  input  logic          rst_n,
  input  logic          in_valid,
  output logic          in_ready,
  input  fu_pkg::tag_t  in_tag,
  input  fu_pkg::word_t in_a,
  input  fu_pkg::word_t in_b,
  output logic          out_valid,
  input  logic          out_ready,
  output fu_pkg::tag_t  out_tag,
  output fu_pkg::word_t out_value
);

  localparam int STAGES = `MULT_STAGES;
  // Bits of b consumed per stage
  localparam int SL = (`XLEN + STAGES - 1) / STAGES;
  localparam fu_pkg::word_t SLICE_MASK = {`XLEN{1'b1}} >> (`XLEN - SL);

  logic [STAGES-1:0] vld_q;
  fu_pkg::tag_t      tag_q [STAGES];
  fu_pkg::word_t     a_q   [STAGES];  // Multiplicand, pre-shifted for the next slice
  fu_pkg::word_t     b_q   [STAGES];  // Multiplier bits still to consume
  fu_pkg::word_t     sum_q [STAGES];  // Running low product
  logic              stall;

  // a times the lowest slice of b, truncated to XLEN
  function automatic fu_pkg::word_t partial(input fu_pkg::word_t x, input fu_pkg::word_t y);
    fu_pkg::word_t slice;
    slice = y & SLICE_MASK;
    return x * slice;
  endfunction

  // Finished product waiting on the completion port freezes everything
  assign stall    = vld_q[STAGES-1] & ~out_ready;
  assign in_ready = ~stall;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else if (!stall) begin
      vld_q <= {vld_q[STAGES-2:0], in_valid};
    end
  end

  always_ff @(posedge clock) begin
    if (!stall) begin
      tag_q[0] <= in_tag;
      a_q[0]   <= in_a << SL;
      b_q[0]   <= in_b >> SL;
      sum_q[0] <= partial(in_a, in_b);
      for (int k = 1; k < STAGES; k++) begin
        tag_q[k] <= tag_q[k-1];
        a_q[k]   <= a_q[k-1] << SL;
        b_q[k]   <= b_q[k-1] >> SL;
        sum_q[k] <= sum_q[k-1] + partial(a_q[k-1], b_q[k-1]);
      end
    end
  end

  assign out_valid = vld_q[STAGES-1];
  assign out_tag   = tag_q[STAGES-1];
  assign out_value = sum_q[STAGES-1];

endmodule

// ==== design/completion_stage.sv ====
module completion_stage (
  input  logic            clock,
  input  logic            rst_n,
  input  logic            issue_valid,
  output logic            issue_ready,
  input  isa_pkg::fu_op_e issue_op,
  input  fu_pkg::tag_t    issue_tag,
  input  fu_pkg::word_t   alu_result,
  input  logic            br_taken,
  input  fu_pkg::word_t   br_target,
  input  fu_pkg::word_t   br_link,
  output logic            mul_in_valid,
  input  logic            mul_in_ready,
  input  logic            mul_out_valid,
  output logic            mul_out_ready,
  input  fu_pkg::tag_t    mul_out_tag,
  input  fu_pkg::word_t   mul_out_value,
  output logic            cpl_valid,
  input  logic            cpl_ready,
  output fu_pkg::tag_t    cpl_tag,
  output fu_pkg::word_t   cpl_value,
  output logic            cpl_taken,
  output fu_pkg::word_t   cpl_target
);

  fu_pkg::exec_class_e cls;
  fu_pkg::cpl_src_e    sel;
  fu_pkg::cpl_src_e    held_q;   // Source stalled last cycle, if any
  logic                int_vld;
  fu_pkg::tag_t        int_tag;
  fu_pkg::word_t       int_value;
  logic                int_taken;
  fu_pkg::word_t       int_target;
  logic                int_drain;
  logic                int_accept;

  always_comb begin
    case (issue_op)
      isa_pkg::OP_MULQ: cls = fu_pkg::CLS_MUL;
      isa_pkg::OP_BR:   cls = fu_pkg::CLS_BR;
      default:          cls = fu_pkg::CLS_INT;
    endcase
  end

  // A stalled pick stays; otherwise the older multiply result wins
  always_comb begin
    if (held_q != fu_pkg::SRC_NONE) sel = held_q;
    else if (mul_out_valid)         sel = fu_pkg::SRC_MUL;
    else if (int_vld)               sel = fu_pkg::SRC_INT;
    else                            sel = fu_pkg::SRC_NONE;
  end

  assign cpl_valid     = (sel != fu_pkg::SRC_NONE);
  assign mul_out_ready = cpl_ready & (sel == fu_pkg::SRC_MUL);
  assign int_drain     = cpl_ready & (sel == fu_pkg::SRC_INT);

  // Integer register takes a new entry when empty or draining now
  assign mul_in_valid = issue_valid & (cls == fu_pkg::CLS_MUL);
  assign issue_ready  = (cls == fu_pkg::CLS_MUL) ? mul_in_ready : (~int_vld | int_drain);
  assign int_accept   = issue_valid & issue_ready & (cls != fu_pkg::CLS_MUL);

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      int_vld <= 1'b0;
      held_q  <= fu_pkg::SRC_NONE;
    end else begin
      held_q <= (cpl_valid && !cpl_ready) ? sel : fu_pkg::SRC_NONE;
      if (int_accept)     int_vld <= 1'b1;
      else if (int_drain) int_vld <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (int_accept) begin
      int_tag    <= issue_tag;
      int_value  <= (cls == fu_pkg::CLS_BR) ? br_link : alu_result;
      int_taken  <= (cls == fu_pkg::CLS_BR) & br_taken;
      int_target <= (cls == fu_pkg::CLS_BR) ? br_target : '0;
    end
  end

  always_comb begin
    case (sel)
      fu_pkg::SRC_MUL: begin
        cpl_tag    = mul_out_tag;
        cpl_value  = mul_out_value;
        cpl_taken  = 1'b0;
        cpl_target = '0;
      end
      fu_pkg::SRC_INT: begin
        cpl_tag    = int_tag;
        cpl_value  = int_value;
        cpl_taken  = int_taken;
        cpl_target = int_target;
      end
      default: begin
        cpl_tag    = '0;
        cpl_value  = '0;
        cpl_taken  = 1'b0;
        cpl_target = '0;
      end
    endcase
  end

endmodule

// ==== design/fu_top.sv ====
module fu_top (
  input  logic              clock,
  input  logic              rst_n,

  // Issue channel
  input  logic              issue_valid,
  output logic              issue_ready,
  input  isa_pkg::fu_op_e   issue_op,
  input  isa_pkg::br_cond_e issue_cond,
  input  fu_pkg::tag_t      issue_tag,
  input  fu_pkg::word_t     issue_a,
  input  fu_pkg::word_t     issue_b,
  input  fu_pkg::word_t     issue_pc,
  input  fu_pkg::word_t     issue_disp,

  // Completion channel, one CDB writer
  output logic              cpl_valid,
  input  logic              cpl_ready,
  output fu_pkg::tag_t      cpl_tag,
  output fu_pkg::word_t     cpl_value,
  output logic              cpl_taken,
  output fu_pkg::word_t     cpl_target
);

  fu_pkg::word_t alu_result;
  logic          br_taken;
  fu_pkg::word_t br_target;
  fu_pkg::word_t br_link;
  logic          mul_in_valid;
  logic          mul_in_ready;
  logic          mul_out_valid;
  logic          mul_out_ready;
  fu_pkg::tag_t  mul_out_tag;
  fu_pkg::word_t mul_out_value;

  alu alu_0 (
    .op     (issue_op),
    .a      (issue_a),
    .b      (issue_b),
    .result (alu_result)
  );

  br_unit br_0 (
    .cond   (issue_cond),
    .a      (issue_a),
    .pc     (issue_pc),
    .disp   (issue_disp),
    .taken  (br_taken),
    .target (br_target),
    .link   (br_link)
  );

  // Operands go straight in; completion_stage gates the valid
  mult_pipe mult_0 (
    .clock     (clock),
    .rst_n     (rst_n),
    .in_valid  (mul_in_valid),
    .in_ready  (mul_in_ready),
    .in_tag    (issue_tag),
    .in_a      (issue_a),
    .in_b      (issue_b),
    .out_valid (mul_out_valid),
    .out_ready (mul_out_ready),
    .out_tag   (mul_out_tag),
    .out_value (mul_out_value)
  );

  completion_stage cpl_0 (
    .clock         (clock),
    .rst_n         (rst_n),
    .issue_valid   (issue_valid),
    .issue_ready   (issue_ready),
    .issue_op      (issue_op),
    .issue_tag     (issue_tag),
    .alu_result    (alu_result),
    .br_taken      (br_taken),
    .br_target     (br_target),
    .br_link       (br_link),
    .mul_in_valid  (mul_in_valid),
    .mul_in_ready  (mul_in_ready),
    .mul_out_valid (mul_out_valid),
    .mul_out_ready (mul_out_ready),
    .mul_out_tag   (mul_out_tag),
    .mul_out_value (mul_out_value),
    .cpl_valid     (cpl_valid),
    .cpl_ready     (cpl_ready),
    .cpl_tag       (cpl_tag),
    .cpl_value     (cpl_value),
    .cpl_taken     (cpl_taken),
    .cpl_target    (cpl_target)
  );

endmodule

// ==== tb/fu_assertions.sv ====
module fu_assertions (
  input logic          clock,
  input logic          rst_n,
  input logic          issue_ready,
  input logic          cpl_valid,
  input logic          cpl_ready,
  input fu_pkg::tag_t  cpl_tag,
  input fu_pkg::word_t cpl_value,
  input logic          cpl_taken,
  input fu_pkg::word_t cpl_target
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;

  // Nothing in flight once a reset edge has passed
  reset_quiet: assert property (@(posedge clock) !rst_n |=> !cpl_valid)
    else begin
      fail_count++;
      $error("cpl_valid raised after a reset edge");
    end

  stall_hold: assert property (@(posedge clock) disable iff (!rst_n)
    cpl_valid && !cpl_ready |=> cpl_valid && $stable(cpl_tag) && $stable(cpl_value)
      && $stable(cpl_taken) && $stable(cpl_target))
    else begin
      fail_count++;
      $error("Completion data changed while cpl_ready was low");
    end

  ready_after_reset: assert property (@(posedge clock) $rose(rst_n) |-> issue_ready)
    else begin
      fail_count++;
      $error("issue_ready low in the first cycle after reset");
    end

endmodule

bind fu_top fu_assertions chk (
  .clock       (clock),
  .rst_n       (rst_n),
  .issue_ready (issue_ready),
  .cpl_valid   (cpl_valid),
  .cpl_ready   (cpl_ready),
  .cpl_tag     (cpl_tag),
  .cpl_value   (cpl_value),
  .cpl_taken   (cpl_taken),
  .cpl_target  (cpl_target)
);

// ==== tb/fu_tb.sv ====
`include "fu_defines.svh"

module fu_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int PERIOD      = 40;
  localparam int RST_CYCLES  = 5;
  localparam int MAX_ENTRIES = 1 << `TAG_W;  // One table entry per tag
  localparam logic [15:0] READY_PATTERN = 16'b1101_1111_0001_1011;  // Used lsb first

  logic              clock;
  logic              rst_n;
  logic              issue_valid;
  logic              issue_ready;
  isa_pkg::fu_op_e   issue_op;
  isa_pkg::br_cond_e issue_cond;
  fu_pkg::tag_t      issue_tag;
  fu_pkg::word_t     issue_a, issue_b, issue_pc, issue_disp;
  logic              cpl_valid;
  logic              cpl_ready;
  fu_pkg::tag_t      cpl_tag;
  fu_pkg::word_t     cpl_value, cpl_target;
  logic              cpl_taken;

  // Stimulus table with expected results, indexed by tag
  isa_pkg::fu_op_e   t_op   [MAX_ENTRIES];
  isa_pkg::br_cond_e t_cond [MAX_ENTRIES];
  fu_pkg::word_t     t_a [MAX_ENTRIES], t_b [MAX_ENTRIES], t_pc [MAX_ENTRIES];
  fu_pkg::word_t     t_disp [MAX_ENTRIES], t_value [MAX_ENTRIES], t_target [MAX_ENTRIES];
  logic              t_taken [MAX_ENTRIES];
  bit                issued [MAX_ENTRIES];
  bit                done   [MAX_ENTRIES];
  time               issue_at [MAX_ENTRIES];  // Negedge before the issue transfer

  int         n_entries = 0;
  int         n_done = 0;
  int         errors = 0;
  integer     seed = 55427;
  logic [3:0] rdy_idx;

  fu_top uut (.*);

  initial clock = 1'b0;
  always #(PERIOD / 2) clock = ~clock;

  task automatic check_value(input string name, input fu_pkg::word_t got,
                             input fu_pkg::word_t exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  function automatic fu_pkg::word_t rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  // Reference results, signed views where the operation is signed
  function automatic fu_pkg::word_t model_value(isa_pkg::fu_op_e op, fu_pkg::word_t a,
                                                fu_pkg::word_t b);
    logic [5:0] sh;
    sh = b[5:0];
    case (op)
      isa_pkg::OP_ADDQ:   return a + b;
      isa_pkg::OP_SUBQ:   return a - b;
      isa_pkg::OP_AND:    return a & b;
      isa_pkg::OP_BIC:    return a & ~b;
      isa_pkg::OP_BIS:    return a | b;
      isa_pkg::OP_ORNOT:  return a | ~b;
      isa_pkg::OP_XOR:    return a ^ b;
      isa_pkg::OP_EQV:    return ~(a ^ b);
      isa_pkg::OP_SRL:    return a >> sh;
      isa_pkg::OP_SLL:    return a << sh;
      isa_pkg::OP_SRA:    return $signed(a) >>> sh;
      isa_pkg::OP_CMPULT: return a < b;
      isa_pkg::OP_CMPEQ:  return a == b;
      isa_pkg::OP_CMPULE: return a <= b;
      isa_pkg::OP_CMPLT:  return $signed(a) < $signed(b);
      isa_pkg::OP_CMPLE:  return $signed(a) <= $signed(b);
      isa_pkg::OP_MULQ:   return a * b;  // Truncated to the low word
      default:            return '0;
    endcase
  endfunction

  function automatic logic model_taken(isa_pkg::br_cond_e cond, fu_pkg::word_t a);
    case (cond)
      isa_pkg::BR_LBC: return !a[0];
      isa_pkg::BR_EQ:  return a == 0;
      isa_pkg::BR_LT:  return $signed(a) < 0;
      isa_pkg::BR_LE:  return $signed(a) <= 0;
      isa_pkg::BR_LBS: return a[0];
      isa_pkg::BR_NE:  return a != 0;
      isa_pkg::BR_GE:  return $signed(a) >= 0;
      default:         return $signed(a) > 0;
    endcase
  endfunction

  task automatic add_entry(input isa_pkg::fu_op_e op, input isa_pkg::br_cond_e cond,
                           input fu_pkg::word_t a, input fu_pkg::word_t b,
                           input fu_pkg::word_t pc, input fu_pkg::word_t disp);
    logic is_br;
    is_br = (op == isa_pkg::OP_BR);
    t_op[n_entries]     = op;
    t_cond[n_entries]   = cond;
    t_a[n_entries]      = a;
    t_b[n_entries]      = b;
    t_pc[n_entries]     = pc;
    t_disp[n_entries]   = disp;
    t_value[n_entries]  = is_br ? pc + `INSN_BYTES : model_value(op, a, b);  // Link for branches
    t_taken[n_entries]  = is_br && model_taken(cond, a);
    t_target[n_entries] = is_br ? pc + `INSN_BYTES + disp * `INSN_BYTES : '0;
    n_entries++;
  endtask

  task automatic add_alu(input isa_pkg::fu_op_e op, input fu_pkg::word_t a,
                         input fu_pkg::word_t b);
    add_entry(op, isa_pkg::BR_LBC, a, b, '0, '0);
  endtask

  task automatic build_table();
    fu_pkg::word_t p;
    fu_pkg::word_t q;
    fu_pkg::word_t w;
    p = 64'hF0F0_1234_5678_9ABC;
    q = 64'h0FF0_FFFF_0000_FFFF;
    add_alu(isa_pkg::OP_ADDQ, 64'h1, '1);  // Wraps to zero
    add_alu(isa_pkg::OP_SUBQ, 64'h0, 64'h1);
    add_alu(isa_pkg::OP_AND, p, q);
    add_alu(isa_pkg::OP_BIC, p, q);
    add_alu(isa_pkg::OP_BIS, p, q);
    add_alu(isa_pkg::OP_ORNOT, p, q);
    add_alu(isa_pkg::OP_XOR, p, q);
    add_alu(isa_pkg::OP_EQV, p, q);
    add_alu(isa_pkg::OP_SRL, 64'h8000_0000_0000_0001, 64'd63);
    add_alu(isa_pkg::OP_SLL, 64'h1, 64'd63);
    add_alu(isa_pkg::OP_SRA, 64'h8000_0000_0000_00F0, 64'd0);
    add_alu(isa_pkg::OP_SRA, 64'h8000_0000_0000_0000, 64'd63);
    add_alu(isa_pkg::OP_SRA, 64'hF000_0000_0000_1234, 64'hFFC4);  // Only low six bits count
    add_alu(isa_pkg::OP_SRA, 64'h7000_0000_0000_0000, 64'd8);
    add_alu(isa_pkg::OP_CMPULT, '1, 64'h1);
    add_alu(isa_pkg::OP_CMPLT, '1, 64'h1);
    add_alu(isa_pkg::OP_CMPULE, 64'h5, 64'h5);
    add_alu(isa_pkg::OP_CMPLE, 64'h1, '1);
    add_alu(isa_pkg::OP_CMPEQ, 64'h5, 64'h5);
    // Back-to-back multiplies, then integer work behind them
    add_alu(isa_pkg::OP_MULQ, 64'hFFFF_FFFF_FFFF_FFFD, 64'd7);
    add_alu(isa_pkg::OP_MULQ, '1, '1);
    add_alu(isa_pkg::OP_MULQ, rand_word(), rand_word());
    add_alu(isa_pkg::OP_MULQ, rand_word(), 64'h8000_0000_0000_0001);
    for (int k = 0; k < 4; k++) begin
      add_alu(isa_pkg::fu_op_e'($unsigned($random(seed)) % 16), rand_word(), rand_word());
    end
    for (int c = 0; c < 8; c++) begin
      for (int k = 0; k < 4; k++) begin
        w = rand_word();
        case (k)
          0:       w = '0;
          1:       w = {1'b0, w[62:1], 1'b1};   // Odd positive
          2:       w = {1'b1, w[62:0]};         // Negative
          default: w = {1'b0, w[62:2], 2'b10};  // Even positive
        endcase
        add_entry(isa_pkg::OP_BR, isa_pkg::br_cond_e'(c), w, rand_word(), rand_word(),
                  rand_word());
      end
    end
    add_alu(isa_pkg::OP_MULQ, rand_word(), rand_word());
    add_alu(isa_pkg::OP_ADDQ, rand_word(), rand_word());
    add_alu(isa_pkg::OP_MULQ, '1, rand_word());
    add_alu(isa_pkg::OP_CMPLT, rand_word(), rand_word());
  endtask

  task automatic record_completion();
    int  t;
    time min_lat;
    t = cpl_tag;
    if (t >= n_entries || !issued[t]) begin
      errors++;
      $display("Completion at %0t carries tag %0d that was never issued", $time, t);
    end else if (done[t]) begin
      errors++;
      $display("Tag %0d completed a second time at %0t", t, $time);
    end else begin
      min_lat = (t_op[t] == isa_pkg::OP_MULQ) ? `MULT_STAGES * PERIOD : PERIOD;
      if ($time - issue_at[t] < min_lat) begin
        errors++;
        $display("Tag %0d completed only %0t after its issue", t, $time - issue_at[t]);
      end
      check_value($sformatf("cpl_value[%0d]", t), cpl_value, t_value[t]);
      check_value($sformatf("cpl_taken[%0d]", t), cpl_taken, t_taken[t]);
      check_value($sformatf("cpl_target[%0d]", t), cpl_target, t_target[t]);
      done[t] = 1'b1;
      n_done++;
    end
  endtask

  // Completion transfers happen at the next rising edge
  always @(negedge clock) begin
    if (rst_n && cpl_valid && cpl_ready) begin
      record_completion();
    end
  end

  always @(posedge clock) begin
    if (!rst_n) begin
      cpl_ready <= 1'b0;
      rdy_idx   <= '0;
    end else begin
      cpl_ready <= READY_PATTERN[rdy_idx];
      rdy_idx   <= rdy_idx + 1'b1;
    end
  end

  initial begin : stimulus
    rst_n       = 1'b0;
    issue_valid = 1'b0;
    issue_op    = isa_pkg::OP_ADDQ;
    issue_cond  = isa_pkg::BR_LBC;
    issue_tag   = '0;
    issue_a     = '0;
    issue_b     = '0;
    issue_pc    = '0;
    issue_disp  = '0;
    cpl_ready   = 1'b0;
    build_table();
    repeat (RST_CYCLES) @(posedge clock);
    rst_n <= 1'b1;
    for (int i = 0; i < n_entries; i++) begin
      issue_valid <= 1'b1;
      issue_op    <= t_op[i];
      issue_cond  <= t_cond[i];
      issue_tag   <= fu_pkg::tag_t'(i);
      issue_a     <= t_a[i];
      issue_b     <= t_b[i];
      issue_pc    <= t_pc[i];
      issue_disp  <= t_disp[i];
      @(negedge clock);
      if (i == 0) begin
        check_value("issue_ready", issue_ready, 1'b1);  // First edge after reset
        check_value("cpl_valid", cpl_valid, 1'b0);
      end
      while (!issue_ready) @(negedge clock);
      issued[i]   = 1'b1;
      issue_at[i] = $time;
      @(posedge clock);
    end
    issue_valid <= 1'b0;
    while (n_done < n_entries) @(negedge clock);
    errors += uut.chk.fail_count;
    $display("Summary: %0d errors, %0d of %0d tags completed", errors, n_done, n_entries);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin : watchdog
    @(posedge rst_n);
    #(n_entries * (`MULT_STAGES + 8) * PERIOD);
    $display("Timeout with only %0d of %0d tags completed", n_done, n_entries);
    $display("Errors found");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+design
design/isa_pkg.sv
design/fu_pkg.sv
design/alu.sv
design/br_unit.sv
design/mult_pipe.sv
design/completion_stage.sv
design/fu_top.sv
tb/fu_assertions.sv
tb/fu_tb.sv
